// ==== src/fetch_pkg.sv ====
// ----------------------------------------------------------------------------
// shared definitions for the instruction fetch front end
// buffer and line constants, cache bus tag and request structs,
// fetch state enum and the decode buffer write struct
// ----------------------------------------------------------------------------

package fetch_pkg;

	// geometry of lines, beats and the decode buffer
	localparam int LINE_BYTES       = 64;
	localparam int BEAT_BYTES       = 8;
	localparam int BUF_BYTES        = 128;
	localparam int FILL_AHEAD_LIMIT = 32; // request a new line only below this gap
	localparam int LINE_OFF_BITS    = $clog2(LINE_BYTES);

	typedef logic [63:0] fetch_addr_t;
	typedef logic [$clog2(BUF_BYTES)-1:0] buf_off_t; // wraps at the buffer size

	// ------------------------------------------------------------------------
	// cache to core bus
	// ------------------------------------------------------------------------
	typedef enum logic {
		cache_write = 1'b0,
		cache_read  = 1'b1
	} cache_op_e;

	typedef enum logic {
		cache_memory = 1'b0,
		cache_io     = 1'b1
	} cache_space_e;

	typedef enum logic {
		cache_data  = 1'b0,
		cache_instr = 1'b1
	} cache_kind_e;

	typedef struct packed {
		cache_op_e    op;
		cache_space_e space;
		cache_kind_e  kind;
		logic [6:0]   id;    // only one request in flight, so this stays zero
	} cache_tag_t;

	typedef struct packed {
		fetch_addr_t addr;
		cache_tag_t  tag;
	} cache_req_t;

	typedef struct packed {
		logic [63:0] data;
	} cache_resp_t;

	// ------------------------------------------------------------------------
	// fetch control and buffer fill
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		fetch_idle,
		fetch_waiting,
		fetch_active
	} fetch_state_e;

	typedef struct packed {
		buf_off_t    offset; // first buffer byte written by this beat
		logic [63:0] data;
	} buf_wr_t;

endpackage

// ==== src/fetch_ctrl.sv ====
// ----------------------------------------------------------------------------
// fetch control FSM
// decides when a line request goes out and which response beats count
// ----------------------------------------------------------------------------

`timescale 1ns/10ps

module fetch_ctrl (
	input  logic                   cacheCoreBus,
	input  logic                   rst_n,
	input  logic                   reqack,
	input  logic                   respcyc,
	input  fetch_pkg::buf_off_t    fill_offset,
	input  fetch_pkg::buf_off_t    decode_offset,
	output logic                   respack,
	output logic                   send_req,
	output logic                   beat_valid,
	output fetch_pkg::fetch_state_e state
);
	import fetch_pkg::*;

	buf_off_t ahead; // bytes fetched but not yet consumed by the decoder

	assign ahead = fill_offset - decode_offset;

	// every response beat is taken as soon as it shows up
	assign respack    = respcyc;
	assign beat_valid = respcyc;

	// a request may only be decided while nothing is in flight
	always_comb begin
		send_req = 1'b0;
		if (state == fetch_idle && !reqack) begin
			send_req = (ahead < buf_off_t'(FILL_AHEAD_LIMIT));
		end
	end

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge cacheCoreBus or negedge rst_n) begin
		if (!rst_n) begin
			state <= fetch_idle;
		end else if (respcyc) begin
			state <= fetch_active;     // first beat of the line moves us on
		end else if (state == fetch_active) begin
			state <= fetch_idle;       // the beats have stopped so the line is done
		end else if (reqack) begin
			state <= fetch_waiting;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// beats only follow an acknowledged request, never an idle decision
	a_no_beat_while_deciding: assert property (
		@(posedge cacheCoreBus) disable iff (!rst_n)
		!(respcyc && send_req)
	) else $error("response beat arrived while a request was being decided");

	// the cache acks a request that the request register put on the bus
	a_ack_only_idle: assert property (
		@(posedge cacheCoreBus) disable iff (!rst_n)
		reqack |-> state == fetch_idle
	) else $error("reqack seen outside the idle state");

endmodule

// ==== src/fetch_req_gen.sv ====
// ----------------------------------------------------------------------------
// line request register
// drives the request strobe, line address and tag onto the cache bus
// ----------------------------------------------------------------------------

`timescale 1ns/10ps

module fetch_req_gen (
	input  logic                  cacheCoreBus,
	input  logic                  rst_n,
	input  logic                  send_req,
	input  fetch_pkg::fetch_addr_t fetch_addr,
	output logic                  reqcyc,
	output fetch_pkg::cache_req_t  req
);
	import fetch_pkg::*;

	cache_tag_t  tag;
	fetch_addr_t line_addr;

	// instruction fetch always reads whole lines from memory
	assign tag.op    = cache_read;
	assign tag.space = cache_memory;
	assign tag.kind  = cache_instr;
	assign tag.id    = '0;

	assign line_addr = fetch_addr & ~fetch_addr_t'(LINE_BYTES - 1);

	// the strobe is the only control bit here
	always_ff @(posedge cacheCoreBus or negedge rst_n) begin
		if (!rst_n) begin
			reqcyc <= 1'b0;
		end else begin
			reqcyc <= send_req; // the bus sees the decision one cycle later
		end
	end

	// address and tag are only looked at while reqcyc is high
	always_ff @(posedge cacheCoreBus) begin
		req.addr <= line_addr;
		req.tag  <= tag;
	end

endmodule

// ==== src/fetch_line_fill.sv ====
// ----------------------------------------------------------------------------
// line fill datapath
// fetch address, skip count for the first line and the buffer fill offset,
// plus the buffer write for every beat that is kept
// ----------------------------------------------------------------------------

`timescale 1ns/10ps

module fetch_line_fill (
	input  logic                   cacheCoreBus,
	input  logic                   rst_n,
	input  fetch_pkg::fetch_addr_t entry,
	input  logic                   beat_valid,
	input  fetch_pkg::cache_resp_t resp,
	output fetch_pkg::fetch_addr_t fetch_addr,
	output fetch_pkg::buf_off_t    fill_offset,
	output logic                   buf_we,
	output fetch_pkg::buf_wr_t     buf_wr
);
	import fetch_pkg::*;

	logic [LINE_OFF_BITS-1:0] skip; // bytes of the first line still to drop
	logic                     skip_done;

	assign skip_done = (skip == '0);

	// a kept beat is written at the current fill offset in the same cycle
	assign buf_we        = beat_valid && skip_done;
	assign buf_wr.offset = fill_offset;
	assign buf_wr.data   = resp.data;

	// ------------------------------------------------------------------------
	// address and offset tracking
	// ------------------------------------------------------------------------
	always_ff @(posedge cacheCoreBus or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr  <= entry & ~fetch_addr_t'(LINE_BYTES - 1);
			skip        <= entry[LINE_OFF_BITS-1:0];
			fill_offset <= '0;
		end else if (beat_valid) begin
			fetch_addr <= fetch_addr + fetch_addr_t'(BEAT_BYTES);

			// beats ahead of the entry point only burn down the skip count
			if (!skip_done) begin
				skip <= skip - LINE_OFF_BITS'(BEAT_BYTES);
			end else begin
				fill_offset <= fill_offset + buf_off_t'(BEAT_BYTES);
			end
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// the skip count only steps in whole beats, so the entry has to match
	a_entry_aligned: assert property (
		@(posedge cacheCoreBus)
		$rose(rst_n) |-> entry[$clog2(BEAT_BYTES)-1:0] == '0
	) else $error("entry address %h is not 8-byte aligned", entry);

endmodule

// ==== src/decode_buffer.sv ====
// ----------------------------------------------------------------------------
// decode buffer
// 128-byte circular byte store filled a beat at a time, with the whole
// buffer and an 8-byte window at the decode offset presented to the decoder
// ----------------------------------------------------------------------------

`timescale 1ns/10ps

module decode_buffer (
	input  logic                                 cacheCoreBus,
	input  logic                                 rst_n,
	input  logic                                 buf_we,
	input  fetch_pkg::buf_wr_t                   buf_wr,
	input  fetch_pkg::buf_off_t                  decode_offset,
	output logic [0:fetch_pkg::BUF_BYTES*8-1]    decode_bytes,
	output logic [63:0]                          window
);
	import fetch_pkg::*;

	logic [7:0] mem [BUF_BYTES];

	// ------------------------------------------------------------------------
	// byte store
	// ------------------------------------------------------------------------

	// beat byte k sits in data bits [8k+7:8k] and lands at offset + k
	always_ff @(posedge cacheCoreBus or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BUF_BYTES; i++) begin
				mem[i] <= '0;
			end
		end else if (buf_we) begin
			for (int k = 0; k < BEAT_BYTES; k++) begin
				mem[buf_wr.offset + buf_off_t'(k)] <= buf_wr.data[8*k +: 8];
			end
		end
	end

	// ------------------------------------------------------------------------
	// read side
	// ------------------------------------------------------------------------

	// flat view for the decoder with byte 0 in the top bits
	always_comb begin
		for (int i = 0; i < BUF_BYTES; i++) begin
			decode_bytes[8*i +: 8] = mem[i];
		end
	end

	// window byte 0 is the byte at decode_offset, in the low bits as on the bus
	always_comb begin
		for (int k = 0; k < BEAT_BYTES; k++) begin
			window[8*k +: 8] = mem[decode_offset + buf_off_t'(k)];
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// fill offsets only move in whole beats, so no write straddles two slots
	a_write_aligned: assert property (
		@(posedge cacheCoreBus) disable iff (!rst_n)
		buf_we |-> buf_wr.offset[$clog2(BEAT_BYTES)-1:0] == '0
	) else $error("buffer write at unaligned offset %h", buf_wr.offset);

endmodule

// ==== src/instr_fetch_top.sv ====
// ----------------------------------------------------------------------------
// instruction fetch front end top level
// control FSM, request register, line fill and decode buffer on the bus
// ----------------------------------------------------------------------------

`timescale 1ns/10ps

module instr_fetch_top (
	input  logic                              cacheCoreBus,
	input  logic                              rst_n,
	input  fetch_pkg::fetch_addr_t            entry,
	input  fetch_pkg::buf_off_t               decode_offset,
	input  logic                              reqack,
	input  logic                              respcyc,
	input  fetch_pkg::cache_resp_t            resp,
	output logic                              reqcyc,
	output logic                              respack,
	output fetch_pkg::cache_req_t             req,
	output fetch_pkg::buf_off_t               fill_offset,
	output logic [0:fetch_pkg::BUF_BYTES*8-1] decode_bytes,
	output logic [63:0]                       window
);
	import fetch_pkg::*;

	logic        send_req;
	logic        beat_valid;
	fetch_addr_t fetch_addr;
	logic        buf_we;
	buf_wr_t     buf_wr;

	fetch_ctrl u_ctrl (
		.cacheCoreBus  (cacheCoreBus),
		.rst_n         (rst_n),
		.reqack        (reqack),
		.respcyc       (respcyc),
		.fill_offset   (fill_offset),
		.decode_offset (decode_offset),
		.respack       (respack),
		.send_req      (send_req),
		.beat_valid    (beat_valid),
		.state         ()            // visible inside the FSM for debug only
	);

	fetch_req_gen u_req_gen (
		.cacheCoreBus (cacheCoreBus),
		.rst_n        (rst_n),
		.send_req     (send_req),
		.fetch_addr   (fetch_addr),
		.reqcyc       (reqcyc),
		.req          (req)
	);

	fetch_line_fill u_line_fill (
		.cacheCoreBus (cacheCoreBus),
		.rst_n        (rst_n),
		.entry        (entry),
		.beat_valid   (beat_valid),
		.resp         (resp),
		.fetch_addr   (fetch_addr),
		.fill_offset  (fill_offset),
		.buf_we       (buf_we),
		.buf_wr       (buf_wr)
	);

	decode_buffer u_decode_buffer (
		.cacheCoreBus  (cacheCoreBus),
		.rst_n         (rst_n),
		.buf_we        (buf_we),
		.buf_wr        (buf_wr),
		.decode_offset (decode_offset),
		.decode_bytes  (decode_bytes),
		.window        (window)
	);

endmodule

// ==== tb/tb_fetch_tasks.svh ====
// ----------------------------------------------------------------------------
// directed tests for the instruction fetch front end
// expected-byte helpers, reset and wait helpers, one task per behavior
// ----------------------------------------------------------------------------

// every byte of instruction memory is its low address byte xor 5a
function automatic logic [7:0] expected_byte(input fetch_addr_t addr);
	return addr[7:0] ^ 8'h5a;
endfunction

// bus order puts the byte at addr in the low bits
function automatic logic [63:0] expected_word(input fetch_addr_t addr);
	logic [63:0] word;
	for (int k = 0; k < BEAT_BYTES; k++) begin
		word[8*k +: 8] = expected_byte(addr + 64'(k));
	end
	return word;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	checks++;
	assert (got === exp) else begin
		errors++;
		$display("ERR %s got %h expected %h", name, got, exp);
	end
endtask

task automatic apply_reset(input fetch_addr_t entry_addr);
	@(negedge cacheCoreBus);
	rst_n         = 1'b0;
	entry         = entry_addr;
	decode_offset = '0;
	repeat (2) @(negedge cacheCoreBus);
	rst_n = 1'b1;
endtask

task automatic wait_request();
	int n;
	n = 0;
	while (!reqcyc && n < WAIT_LIMIT) begin
		@(negedge cacheCoreBus);
		n++;
	end
	assert (reqcyc) else begin
		errors++;
		$display("no line request was offered within %0d cycles", WAIT_LIMIT);
	end
endtask

// respcyc is sampled on the rising edge, away from where the model drives it
task automatic wait_line_done();
	int n;
	n = 0;
	@(posedge cacheCoreBus);
	while (!respcyc && n < WAIT_LIMIT) begin
		@(posedge cacheCoreBus);
		n++;
	end
	while (respcyc && n < WAIT_LIMIT) begin
		@(posedge cacheCoreBus);
		n++;
	end
	assert (n < WAIT_LIMIT) else begin
		errors++;
		$display("response line did not complete within %0d cycles", WAIT_LIMIT);
	end
	@(negedge cacheCoreBus);
endtask

task automatic check_buffer(input fetch_addr_t base, input int count);
	for (int i = 0; i < count; i++) begin
		check_value($sformatf("decode_bytes[%0d]", i), 64'(decode_bytes[8*i +: 8]),
			64'(expected_byte(base + 64'(i))));
	end
endtask

// ----------------------------------------------------------------------------
// tests
// ----------------------------------------------------------------------------
task automatic test_reset_and_first_request();
	fetch_addr_t entry_addr;
	entry_addr = 64'h0000_0000_8000_1010;
	apply_reset(entry_addr);
	check_value("reqcyc", 64'(reqcyc), 64'h0);
	check_value("fill_offset", 64'(fill_offset), 64'h0);
	wait_request();
	check_value("req.addr", req.addr, entry_addr & ~64'h3f);
	check_value("req.tag.op", 64'(req.tag.op), 64'(cache_read));
	check_value("req.tag.space", 64'(req.tag.space), 64'(cache_memory));
	check_value("req.tag.kind", 64'(req.tag.kind), 64'(cache_instr));
	check_value("req.tag.id", 64'(req.tag.id), 64'h0);
	wait_line_done(); // leave the bus quiet for the next reset
endtask

task automatic test_aligned_entry();
	apply_reset(64'h4440);
	wait_line_done();
	check_value("fill_offset", 64'(fill_offset), 64'd64);
	check_buffer(64'h4440, LINE_BYTES);
endtask

task automatic test_unaligned_entry();
	apply_reset(64'h7018);     // three beats of line 7000 are dropped
	wait_line_done();
	check_value("fill_offset", 64'(fill_offset), 64'd40);
	check_buffer(64'h7018, 40);
endtask

task automatic test_back_pressure();
	apply_reset(64'h5000);
	wait_line_done();
	for (int i = 0; i < 50; i++) begin
		check_value("reqcyc", 64'(reqcyc), 64'h0);
		@(negedge cacheCoreBus);
	end
endtask

task automatic test_consume_and_wrap();
	fetch_addr_t entry_addr;
	fetch_addr_t next_line;
	buf_off_t    ahead;
	logic        prev_reqcyc;
	int          consumed;
	int          n;
	entry_addr  = 64'h6000;
	next_line   = entry_addr;
	prev_reqcyc = 1'b0;
	consumed    = 0;
	n           = 0;
	apply_reset(entry_addr);
	while (consumed < 4 * LINE_BYTES && n < CONSUME_LIMIT) begin
		@(negedge cacheCoreBus);
		n++;
		if (reqcyc && !prev_reqcyc) begin
			check_value("req.addr", req.addr, next_line);
			next_line = next_line + 64'(LINE_BYTES);
		end
		prev_reqcyc = reqcyc;
		ahead = fill_offset - decode_offset;
		if (ahead >= buf_off_t'(BEAT_BYTES)) begin
			check_value($sformatf("window at %0d", decode_offset), window,
				expected_word(entry_addr + 64'(consumed)));
			decode_offset = decode_offset + buf_off_t'(BEAT_BYTES);
			consumed += BEAT_BYTES;
		end
	end
	assert (consumed == 4 * LINE_BYTES) else begin
		errors++;
		$display("decoder consumed only %0d of %0d bytes", consumed, 4 * LINE_BYTES);
	end
	// four full lines take the fill offset twice round the buffer
	check_value("fill_offset", 64'(fill_offset), 64'((4 * LINE_BYTES) % BUF_BYTES));
	assert (next_line >= entry_addr + 64'(4 * LINE_BYTES)) else begin
		errors++;
		$display("fewer than four line requests were seen");
	end
endtask

// ==== tb/tb_instr_fetch.sv ====
// ----------------------------------------------------------------------------
// testbench top for the instruction fetch front end
// clock, reset, DUT, cache responder model, respack monitor,
// timeout watchdog and the closing summary
// ----------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_instr_fetch;
	import fetch_pkg::*;

	localparam int WAIT_LIMIT     = 64;  // cycles any single wait may take
	localparam int CONSUME_LIMIT  = 200; // cycles for the four line decode run
	localparam int TEST_CYCLES    = 30 + 30 + 30 + 80 + CONSUME_LIMIT;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + 150;

	logic                    cacheCoreBus = 1'b0;
	logic                    rst_n;
	fetch_addr_t             entry;
	buf_off_t                decode_offset;
	logic                    reqack  = 1'b0; // driven by the cache model only
	logic                    respcyc = 1'b0;
	cache_resp_t             resp    = '0;
	logic                    reqcyc;
	logic                    respack;
	cache_req_t              req;
	buf_off_t                fill_offset;
	logic [0:BUF_BYTES*8-1]  decode_bytes;
	logic [63:0]             window;

	integer seed = 32'h667483ba;
	int     errors = 0;
	int     ack_errors = 0;  // counted by the respack monitor
	int     checks = 0;
	int     cycles = 0;

	always #4 cacheCoreBus = ~cacheCoreBus;

	instr_fetch_top dut0 (
		.cacheCoreBus  (cacheCoreBus),
		.rst_n         (rst_n),
		.entry         (entry),
		.decode_offset (decode_offset),
		.reqack        (reqack),
		.respcyc       (respcyc),
		.resp          (resp),
		.reqcyc        (reqcyc),
		.respack       (respack),
		.req           (req),
		.fill_offset   (fill_offset),
		.decode_bytes  (decode_bytes),
		.window        (window)
	);

	`include "tb_fetch_tasks.svh"

	// ------------------------------------------------------------------------
	// cache model: one ack after a short random delay, then eight beats
	// ------------------------------------------------------------------------
	always begin : cache_responder
		fetch_addr_t line_addr;
		int          delay;
		@(negedge cacheCoreBus);
		if (rst_n && reqcyc) begin
			line_addr = req.addr;
			delay = 1 + int'($unsigned($random(seed)) % 32'd4);
			repeat (delay - 1) @(negedge cacheCoreBus);
			reqack = 1'b1;
			@(negedge cacheCoreBus);
			reqack = 1'b0;
			for (int j = 0; j < LINE_BYTES / BEAT_BYTES; j++) begin
				respcyc   = 1'b1;
				resp.data = expected_word(line_addr + 64'(j * BEAT_BYTES));
				@(negedge cacheCoreBus);
			end
			respcyc = 1'b0;
			resp    = '0;
		end
	end

	// respack has to follow respcyc in every cycle of every test
	always @(posedge cacheCoreBus) begin
		if (rst_n) begin
			assert (respack === respcyc) else begin
				ack_errors++;
				$display("ERR respack got %h expected %h", respack, respcyc);
			end
		end
	end

	// ------------------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------------------
	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge cacheCoreBus);
			cycles++;
		end
		$display("run stopped after %0d cycles without finishing the tests", cycles);
		$display("summary: %0d value checks, %0d errors", checks, errors + ack_errors + 1);
		$display("TESTS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin : main
		rst_n         = 1'b0;
		entry         = '0;
		decode_offset = '0;

		test_reset_and_first_request();
		test_aligned_entry();
		test_unaligned_entry();
		test_back_pressure();
		test_consume_and_wrap();

		$display("summary: %0d value checks, %0d errors", checks, errors + ack_errors);
		if (errors + ack_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== instr_fetch_top.f ====
+incdir+tb
src/fetch_pkg.sv
src/fetch_ctrl.sv
src/fetch_req_gen.sv
src/fetch_line_fill.sv
src/decode_buffer.sv
src/instr_fetch_top.sv
tb/tb_instr_fetch.sv

// ==== Makefile ====
# Verilator build and run for the instruction fetch front end

VERILATOR = verilator
TOP       = tb_instr_fetch
FILELIST  = instr_fetch_top.f
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
